//--- Bender.yml
package:
  name: ctm_msp430

sources:
  - files:
      - hw/ctm_pkg.sv
      - hw/ctm_reg_block.sv
      - hw/ctm_call_detect.sv
      - hw/ctm_packetizer.sv
      - hw/ctm_msp430.sv
  - target: test
    files:
      - verification/ctm_clk_gen.sv
      - verification/ctm_checker.sv
      - verification/ctm_tb.sv

//--- files.f
hw/ctm_pkg.sv
hw/ctm_reg_block.sv
hw/ctm_call_detect.sv
hw/ctm_packetizer.sv
hw/ctm_msp430.sv
verification/ctm_clk_gen.sv
verification/ctm_checker.sv
verification/ctm_tb.sv

//--- hw/ctm_call_detect.sv
module ctm_call_detect (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  input  ctm_pkg::trace_exec_t  trace_port,
  output ctm_pkg::trace_event_t trace_event,
  output logic                  event_valid
);

  ctm_pkg::stamp_t      stamp_cnt; // Free-running cycle count.
  ctm_pkg::event_kind_t ev_kind;
  logic                 qualify;

  // Only calls and returns are kept.
  assign qualify = enable && trace_port.valid && (trace_port.jal || trace_port.jr);

  // jal wins when both are flagged.
  assign ev_kind = trace_port.jal ? ctm_pkg::EV_CALL : ctm_pkg::EV_RETURN;

  ////////////////////////////////////////////////////////////
  // Timestamp.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) stamp_cnt <= '0;
    else stamp_cnt <= stamp_cnt + 16'd1; // Wraps.
  end

  ////////////////////////////////////////////////////////////
  // Event register.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) event_valid <= 1'b0;
    else event_valid <= qualify; // One cycle after the entry.
  end

  // Payload only.
  always_ff @(posedge clk) begin
    if (qualify) begin
      trace_event.kind   <= ev_kind;
      trace_event.pc     <= trace_port.pc;
      trace_event.target <= trace_port.jbtarget;
      trace_event.stamp  <= stamp_cnt; // Stamp of the entry cycle.
    end
  end

endmodule

//--- hw/ctm_msp430.sv
module ctm_msp430 (
  input  logic                 clk,
  input  logic                 rst_n,
  input  ctm_pkg::word_t       id,              // Our network address.
  input  ctm_pkg::dii_flit_t   debug_in,
  output logic                 debug_in_ready,
  output ctm_pkg::dii_flit_t   debug_out,
  input  logic                 debug_out_ready,
  input  ctm_pkg::trace_exec_t trace_port
);

  ////////////////////////////////////////////////////////////
  // Internal links.
  ////////////////////////////////////////////////////////////

  logic                  enable;      // CTRL bit 0.
  ctm_pkg::word_t        trace_dest;
  ctm_pkg::resp_t        resp;
  logic                  resp_valid;
  logic                  resp_taken;
  logic                  drop;        // Event lost, store full.
  ctm_pkg::trace_event_t trace_event;
  logic                  event_valid;

  // Register requests in, configuration out.
  ctm_reg_block u_reg_block (
    .clk            (clk),
    .rst_n          (rst_n),
    .id             (id),
    .debug_in       (debug_in),
    .debug_in_ready (debug_in_ready),
    .enable         (enable),
    .trace_dest     (trace_dest),
    .resp           (resp),
    .resp_valid     (resp_valid),
    .resp_taken     (resp_taken),
    .drop           (drop)
  );

  // Calls and returns only.
  ctm_call_detect u_call_detect (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable      (enable),
    .trace_port  (trace_port),
    .trace_event (trace_event),
    .event_valid (event_valid)
  );

  // Outgoing flit stream.
  ctm_packetizer u_packetizer (
    .clk             (clk),
    .rst_n           (rst_n),
    .id              (id),
    .trace_dest      (trace_dest),
    .trace_event     (trace_event),
    .event_valid     (event_valid),
    .resp            (resp),
    .resp_valid      (resp_valid),
    .resp_taken      (resp_taken),
    .drop            (drop),
    .debug_out       (debug_out),
    .debug_out_ready (debug_out_ready)
  );

endmodule

//--- hw/ctm_packetizer.sv
module ctm_packetizer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ctm_pkg::word_t        id,
  input  ctm_pkg::word_t        trace_dest,
  input  ctm_pkg::trace_event_t trace_event,
  input  logic                  event_valid,
  input  ctm_pkg::resp_t        resp,
  input  logic                  resp_valid,
  output logic                  resp_taken,
  output logic                  drop,
  output ctm_pkg::dii_flit_t    debug_out,
  input  logic                  debug_out_ready
);

  typedef logic [$clog2(ctm_pkg::MAX_PKT_LEN)-1:0] flit_idx_t;

  typedef enum logic [1:0] {
    TX_IDLE,  // Packet boundary.
    TX_RESP,
    TX_TRACE
  } tx_state_e;

  tx_state_e             state;
  flit_idx_t             idx;       // Flit within the packet.
  ctm_pkg::word_t        dest_q;    // Trace destination, fixed per packet.
  ctm_pkg::trace_event_t ev_mem [2];
  ctm_pkg::trace_event_t cur_ev;
  logic                  wr_ptr, rd_ptr;
  logic [1:0]            count;     // Includes the event in flight.
  logic                  full, push, pop, accept, last_flit;

  assign full   = count == 2'd2;
  assign push   = event_valid && !full;
  assign accept = debug_out.valid && debug_out_ready;
  assign cur_ev = ev_mem[rd_ptr];

  always_comb begin
    case (state)
      TX_RESP:  last_flit = idx == flit_idx_t'(ctm_pkg::RESP_PKT_LEN - 1);
      TX_TRACE: last_flit = idx == flit_idx_t'(ctm_pkg::MAX_PKT_LEN - 1);
      default:  last_flit = 1'b0;
    endcase
  end

  // Slot frees only once its last flit is taken.
  assign pop        = accept && last_flit && (state == TX_TRACE);
  assign resp_taken = accept && last_flit && (state == TX_RESP);

  ////////////////////////////////////////////////////////////
  // Two-entry event store.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) ev_mem[wr_ptr] <= trace_event;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
      drop   <= 1'b0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop)  rd_ptr <= ~rd_ptr;
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
      drop <= event_valid && full; // One-cycle pulse per lost event.
    end
  end

  ////////////////////////////////////////////////////////////
  // Serializer.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= TX_IDLE;
      idx   <= '0;
    end else if (state == TX_IDLE) begin
      idx <= '0;
      if (resp_valid) state <= TX_RESP; // Responses first.
      else if (count != 2'd0) state <= TX_TRACE;
    end else if (accept) begin
      idx <= idx + flit_idx_t'(1);
      if (last_flit) state <= TX_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if ((state == TX_IDLE) && !resp_valid) dest_q <= trace_dest;
  end

  // Flit mux, steady while not accepted.
  always_comb begin
    debug_out.valid = state != TX_IDLE;
    debug_out.last  = last_flit;
    debug_out.data  = '0;
    if (state == TX_RESP) begin
      case (idx)
        3'd0:    debug_out.data = resp.dest;
        3'd1:    debug_out.data = id;
        3'd2:    debug_out.data = resp.is_error ? ctm_pkg::TYPE_REG_ERROR
                                                : ctm_pkg::TYPE_REG_RESP;
        default: debug_out.data = resp.data;
      endcase
    end else if (state == TX_TRACE) begin
      case (idx)
        3'd0:    debug_out.data = dest_q;
        3'd1:    debug_out.data = id;
        3'd2:    debug_out.data = ctm_pkg::TYPE_TRACE;
        3'd3:    debug_out.data = cur_ev.stamp;
        3'd4:    debug_out.data = cur_ev.pc;
        3'd5:    debug_out.data = cur_ev.target;
        default: debug_out.data = ctm_pkg::word_t'(cur_ev.kind);
      endcase
    end
  end

endmodule

//--- hw/ctm_pkg.sv
package ctm_pkg;

  ////////////////////////////////////////////////////////////
  // Widths with a meaning.
  ////////////////////////////////////////////////////////////

  typedef logic [15:0] word_t;  // Flit payload and register word.
  typedef logic [15:0] pc_t;    // MSP430 code address.
  typedef logic [15:0] stamp_t; // Cycle timestamp.

  // One word on the debug network.
  typedef struct packed {
    logic  valid;
    logic  last; // Final flit of a packet.
    word_t data;
  } dii_flit_t;

  // Retired control transfer, as reported by the core.
  typedef struct packed {
    logic valid;
    pc_t  pc;
    pc_t  jbtarget; // Jump or branch target.
    logic jal;      // Jump-and-link, kept as a call.
    logic jr;       // Jump-register, kept as a return.
  } trace_exec_t;

  typedef enum logic [1:0] {
    EV_CALL   = 2'd1,
    EV_RETURN = 2'd2
  } event_kind_t;

  // Time-stamped event, one trace packet.
  typedef struct packed {
    event_kind_t kind;
    pc_t         pc;
    pc_t         target;
    stamp_t      stamp;
  } trace_event_t;

  // Pending register response.
  typedef struct packed {
    word_t dest;     // Requester address.
    logic  is_error;
    word_t data;
  } resp_t;

  ////////////////////////////////////////////////////////////
  // Packet types, register map, lengths.
  ////////////////////////////////////////////////////////////

  localparam word_t TYPE_REG_READ  = 16'd1;
  localparam word_t TYPE_REG_WRITE = 16'd2;
  localparam word_t TYPE_REG_RESP  = 16'd3;
  localparam word_t TYPE_REG_ERROR = 16'd4;
  localparam word_t TYPE_TRACE     = 16'd5;

  localparam word_t REG_MOD_TYPE = 16'd0; // Read only.
  localparam word_t REG_CTRL     = 16'd1; // Bit 0 is enable.
  localparam word_t REG_DEST     = 16'd2; // Trace destination.
  localparam word_t REG_DROP     = 16'd3; // Read only, dropped events.

  localparam word_t MOD_TYPE_CTM = 16'h0005;

  localparam int MAX_PKT_LEN  = 7; // Trace packet, the longest.
  localparam int RESP_PKT_LEN = 4; // Dest, src, type, data.

endpackage

//--- hw/ctm_reg_block.sv
module ctm_reg_block (
  input  logic               clk,
  input  logic               rst_n,
  input  ctm_pkg::word_t     id,
  input  ctm_pkg::dii_flit_t debug_in,
  output logic               debug_in_ready,
  output logic               enable,
  output ctm_pkg::word_t     trace_dest,
  output ctm_pkg::resp_t     resp,
  output logic               resp_valid,
  input  logic               resp_taken,
  input  logic               drop
);

  // One state per request word, then skip or respond.
  typedef enum logic [2:0] {
    ST_DEST,
    ST_SRC,
    ST_TYPE,
    ST_ADDR,
    ST_DATA,
    ST_SKIP, // Extra words up to last.
    ST_RESP  // Waiting for the packetizer.
  } reg_state_e;

  reg_state_e     state;
  logic           match_q;           // Request is addressed to us.
  ctm_pkg::word_t src_q, type_q, addr_q;
  ctm_pkg::word_t drop_cnt;
  ctm_pkg::word_t dec_addr, rd_data;
  logic           rd_err, wr_err;
  logic           flit_in, is_read, is_write;

  assign debug_in_ready = state != ST_RESP; // Blocked while a response is pending.
  assign resp_valid     = state == ST_RESP;
  assign flit_in        = debug_in.valid && debug_in_ready;

  // Address word is live on the bus for reads, held for writes.
  assign dec_addr = (state == ST_ADDR) ? debug_in.data : addr_q;

  assign is_read  = flit_in && debug_in.last && (state == ST_ADDR) && match_q &&
                    (type_q == ctm_pkg::TYPE_REG_READ);
  assign is_write = flit_in && debug_in.last && (state == ST_DATA) && match_q &&
                    (type_q == ctm_pkg::TYPE_REG_WRITE);

  ////////////////////////////////////////////////////////////
  // Request FSM.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_DEST;
    end else if (state == ST_RESP) begin
      if (resp_taken) state <= ST_DEST;
    end else if (flit_in) begin
      if (is_read || is_write) state <= ST_RESP;
      else if (debug_in.last) state <= ST_DEST; // Foreign or malformed, drop it.
      else begin
        case (state)
          ST_DEST: state <= ST_SRC;
          ST_SRC:  state <= ST_TYPE;
          ST_TYPE: state <= ST_ADDR;
          ST_ADDR: state <= ST_DATA;
          default: state <= ST_SKIP;
        endcase
      end
    end
  end

  // Header words.
  always_ff @(posedge clk) begin
    if (flit_in) begin
      if (state == ST_DEST) match_q <= debug_in.data == id;
      if (state == ST_SRC)  src_q   <= debug_in.data;
      if (state == ST_TYPE) type_q  <= debug_in.data;
      if (state == ST_ADDR) addr_q  <= debug_in.data;
    end
  end

  // Address decode.
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    wr_err  = 1'b0;
    case (dec_addr)
      ctm_pkg::REG_MOD_TYPE: begin
        rd_data = ctm_pkg::MOD_TYPE_CTM;
        wr_err  = 1'b1; // Read only.
      end
      ctm_pkg::REG_CTRL: rd_data = {15'd0, enable};
      ctm_pkg::REG_DEST: rd_data = trace_dest;
      ctm_pkg::REG_DROP: begin
        rd_data = drop_cnt;
        wr_err  = 1'b1;
      end
      default: begin
        rd_err = 1'b1; // Unknown address.
        wr_err = 1'b1;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Configuration and counters.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable     <= 1'b0;
      trace_dest <= '0;
    end else if (is_write && !wr_err) begin
      if (addr_q == ctm_pkg::REG_CTRL) enable     <= debug_in.data[0];
      if (addr_q == ctm_pkg::REG_DEST) trace_dest <= debug_in.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) drop_cnt <= '0;
    else if (drop && (drop_cnt != '1)) drop_cnt <= drop_cnt + 16'd1; // Saturates.
  end

  // Response payload, held through ST_RESP.
  always_ff @(posedge clk) begin
    if (is_read || is_write) begin
      resp.dest     <= src_q;
      resp.is_error <= is_read ? rd_err : wr_err;
      resp.data     <= (is_read && !rd_err) ? rd_data : '0; // Writes answer 0.
    end
  end

endmodule

//--- verification/ctm_checker.sv
module ctm_checker (
  input logic               clk,
  input logic               rst_n,
  input ctm_pkg::dii_flit_t debug_in,
  input logic               debug_in_ready,
  input ctm_pkg::dii_flit_t debug_out,
  input logic               debug_out_ready
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned assert_fails = 0; // Read by the testbench at the end.
  int unsigned req_open;         // Requests still owed a response.
  logic [2:0]  out_idx;          // Flit position on debug_out.
  logic        resp_type;        // Type word of a response packet.
  logic        req_end;

  assign req_end   = debug_in.valid && debug_in_ready && debug_in.last;
  assign resp_type = debug_out.valid && (out_idx == 3'd2) &&
                     ((debug_out.data == ctm_pkg::TYPE_REG_RESP) ||
                      (debug_out.data == ctm_pkg::TYPE_REG_ERROR));

  ////////////////////////////////////////////////////////////
  // Bookkeeping.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_open <= 0;
      out_idx  <= 3'd0;
    end else begin
      if (debug_out.valid && debug_out_ready) begin
        out_idx <= debug_out.last ? 3'd0 : out_idx + 3'd1;
      end
      case ({req_end, resp_type && debug_out_ready})
        2'b10:   req_open <= req_open + 1;
        2'b01:   req_open <= (req_open != 0) ? req_open - 1 : 0;
        default: req_open <= req_open; // Both or neither.
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Handshake rules.
  ////////////////////////////////////////////////////////////

  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    debug_out.valid && !debug_out_ready |=> $stable(debug_out))
  else begin
    assert_fails++;
    $error("debug_out changed while stalled");
  end

  a_out_reset: assert property (@(posedge clk) !rst_n |-> !debug_out.valid)
  else begin
    assert_fails++;
    $error("debug_out valid during reset");
  end

  a_resp_req: assert property (@(posedge clk) disable iff (!rst_n)
    resp_type |-> (req_open != 0))
  else begin
    assert_fails++;
    $error("response sent with no request pending");
  end

endmodule

bind ctm_msp430 ctm_checker u_checker (
  .clk             (clk),
  .rst_n           (rst_n),
  .debug_in        (debug_in),
  .debug_in_ready  (debug_in_ready),
  .debug_out       (debug_out),
  .debug_out_ready (debug_out_ready)
);

//--- verification/ctm_clk_gen.sv
module ctm_clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period.
  end

  // Low for three rising edges.
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1; // Released off the edge.
  end

endmodule

//--- verification/ctm_tb.sv
module ctm_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam ctm_pkg::word_t DUT_ID   = 16'h0002;
  localparam ctm_pkg::word_t HOST_ID  = 16'h0001; // Requester.
  localparam ctm_pkg::word_t TRACE_TO = 16'h0010;
  localparam int             TIMEOUT  = 200;      // Cycles per wait.
  localparam int             QUIET    = 40;       // No-packet window.

  logic                 clk;
  logic                 rst_n;
  ctm_pkg::word_t       id;
  ctm_pkg::dii_flit_t   debug_in;
  logic                 debug_in_ready;
  ctm_pkg::dii_flit_t   debug_out;
  logic                 debug_out_ready;
  ctm_pkg::trace_exec_t trace_port;

  int             errors;
  string          cur_test;
  ctm_pkg::word_t tx_words [$]; // Packet to send.
  ctm_pkg::word_t rx_data [$];  // Packet received.
  logic           rx_last [$];

  ctm_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  ctm_msp430 ctm_msp430_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .id              (id),
    .debug_in        (debug_in),
    .debug_in_ready  (debug_in_ready),
    .debug_out       (debug_out),
    .debug_out_ready (debug_out_ready),
    .trace_port      (trace_port)
  );

  ////////////////////////////////////////////////////////////
  // Helpers. All run 1 ns after the rising edge.
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string what, input ctm_pkg::word_t exp,
                            input ctm_pkg::word_t act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic send_packet();
    int wait_cnt;
    foreach (tx_words[i]) begin
      debug_in.valid = 1'b1;
      debug_in.last  = (i == tx_words.size() - 1);
      debug_in.data  = tx_words[i];
      wait_cnt = 0;
      while (!debug_in_ready && wait_cnt < TIMEOUT) begin
        @(posedge clk);
        #1;
        wait_cnt++;
      end
      if (!debug_in_ready) begin
        errors++;
        $display("%s: debug_in never became ready", cur_test);
        debug_in = '0;
        return;
      end
      @(posedge clk); // Flit taken here.
      #1;
    end
    debug_in = '0;
  endtask

  task automatic recv_packet(input string what);
    int wait_cnt;
    bit done;
    rx_data.delete();
    rx_last.delete();
    wait_cnt = 0;
    done     = 1'b0;
    while (!done && wait_cnt < TIMEOUT) begin
      if (debug_out.valid && debug_out_ready) begin
        rx_data.push_back(debug_out.data);
        rx_last.push_back(debug_out.last);
        done = debug_out.last;
      end
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    if (!done) begin
      errors++;
      $display("%s: no complete %s within %0d cycles", cur_test, what, TIMEOUT);
    end
  endtask

  // One register request and its response.
  task automatic reg_access(input logic write, input ctm_pkg::word_t addr,
                            input ctm_pkg::word_t wdata, output ctm_pkg::word_t rtype,
                            output ctm_pkg::word_t rdata);
    rtype    = '1;
    rdata    = '1;
    tx_words = {DUT_ID, HOST_ID,
                (write ? ctm_pkg::TYPE_REG_WRITE : ctm_pkg::TYPE_REG_READ), addr};
    if (write) tx_words.push_back(wdata);
    send_packet();
    recv_packet("register response");
    check_word("response length", 16'd4, ctm_pkg::word_t'(rx_data.size()));
    if (rx_data.size() == 4) begin
      check_word("response dest", HOST_ID, rx_data[0]);
      check_word("response src", DUT_ID, rx_data[1]);
      check_word("response last", 16'd1, ctm_pkg::word_t'(rx_last[3]));
      rtype = rx_data[2];
      rdata = rx_data[3];
    end
  endtask

  task automatic drive_entry(input ctm_pkg::pc_t pc, input ctm_pkg::pc_t target,
                             input logic jal, input logic jr);
    trace_port.valid    = 1'b1;
    trace_port.pc       = pc;
    trace_port.jbtarget = target;
    trace_port.jal      = jal;
    trace_port.jr       = jr;
    @(posedge clk);
    #1;
    trace_port = '0; // One retired entry only.
  endtask

  task automatic check_trace(input ctm_pkg::word_t kind, input ctm_pkg::pc_t pc,
                             input ctm_pkg::pc_t target, output ctm_pkg::stamp_t stamp);
    stamp = '0;
    recv_packet("trace packet");
    check_word("trace length", 16'd7, ctm_pkg::word_t'(rx_data.size()));
    if (rx_data.size() == 7) begin
      check_word("trace dest", TRACE_TO, rx_data[0]);
      check_word("trace src", DUT_ID, rx_data[1]);
      check_word("trace type", ctm_pkg::TYPE_TRACE, rx_data[2]);
      check_word("trace pc", pc, rx_data[4]);
      check_word("trace target", target, rx_data[5]);
      check_word("trace kind", kind, rx_data[6]);
      foreach (rx_last[i]) begin // Final only.
        check_word("last flag", ctm_pkg::word_t'(i == 6), ctm_pkg::word_t'(rx_last[i]));
      end
      stamp = rx_data[3];
    end
  endtask

  task automatic expect_quiet(input string what);
    bit seen;
    seen = 1'b0;
    for (int cyc = 0; cyc < QUIET; cyc++) begin
      if (debug_out.valid) seen = 1'b1;
      @(posedge clk);
      #1;
    end
    if (seen) begin
      errors++;
      $display("%s: unexpected packet after %s", cur_test, what);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests.
  ////////////////////////////////////////////////////////////

  task automatic test_mod_type();
    ctm_pkg::word_t rtype, rdata;
    cur_test = "mod_type";
    reg_access(1'b0, ctm_pkg::REG_MOD_TYPE, '0, rtype, rdata);
    check_word("type", ctm_pkg::TYPE_REG_RESP, rtype);
    check_word("data", ctm_pkg::MOD_TYPE_CTM, rdata);
  endtask

  task automatic test_config();
    ctm_pkg::word_t rtype, rdata;
    cur_test = "config";
    reg_access(1'b1, ctm_pkg::REG_CTRL, 16'd1, rtype, rdata);
    check_word("ctrl write type", ctm_pkg::TYPE_REG_RESP, rtype);
    check_word("ctrl write data", 16'd0, rdata);
    reg_access(1'b1, ctm_pkg::REG_DEST, TRACE_TO, rtype, rdata);
    check_word("dest write type", ctm_pkg::TYPE_REG_RESP, rtype);
    check_word("dest write data", 16'd0, rdata);
    reg_access(1'b0, ctm_pkg::REG_CTRL, '0, rtype, rdata);
    check_word("ctrl read", 16'd1, rdata);
    reg_access(1'b0, ctm_pkg::REG_DEST, '0, rtype, rdata);
    check_word("dest read", TRACE_TO, rdata);
  endtask

  task automatic test_trace();
    ctm_pkg::pc_t    pc, target;
    ctm_pkg::stamp_t call_stamp, ret_stamp;
    cur_test = "trace";
    pc       = ctm_pkg::pc_t'($urandom());
    target   = ctm_pkg::pc_t'($urandom());
    drive_entry(pc, target, 1'b1, 1'b0);
    check_trace(ctm_pkg::word_t'(ctm_pkg::EV_CALL), pc, target, call_stamp);
    pc     = ctm_pkg::pc_t'($urandom());
    target = ctm_pkg::pc_t'($urandom());
    drive_entry(pc, target, 1'b0, 1'b1);
    check_trace(ctm_pkg::word_t'(ctm_pkg::EV_RETURN), pc, target, ret_stamp);
    if (ret_stamp <= call_stamp) begin
      errors++;
      $display("mismatch %s return stamp: expected above %h, actual %h",
               cur_test, call_stamp, ret_stamp);
    end
  endtask

  task automatic test_no_event();
    ctm_pkg::word_t rtype, rdata;
    cur_test = "no_event";
    drive_entry(ctm_pkg::pc_t'($urandom()), ctm_pkg::pc_t'($urandom()), 1'b0, 1'b0);
    expect_quiet("an entry without jal or jr");
    reg_access(1'b1, ctm_pkg::REG_CTRL, 16'd0, rtype, rdata);
    check_word("ctrl write type", ctm_pkg::TYPE_REG_RESP, rtype);
    drive_entry(ctm_pkg::pc_t'($urandom()), ctm_pkg::pc_t'($urandom()), 1'b1, 1'b0);
    expect_quiet("a jal entry with tracing off");
  endtask

  task automatic test_backpressure();
    ctm_pkg::word_t  rtype, rdata;
    ctm_pkg::pc_t    pcs [5];
    ctm_pkg::pc_t    tgts [5];
    ctm_pkg::stamp_t stamp;
    cur_test = "backpressure";
    reg_access(1'b1, ctm_pkg::REG_CTRL, 16'd1, rtype, rdata);
    debug_out_ready = 1'b0; // Stall the network.
    for (int i = 0; i < 5; i++) begin
      pcs[i]  = ctm_pkg::pc_t'($urandom());
      tgts[i] = ctm_pkg::pc_t'($urandom());
      drive_entry(pcs[i], tgts[i], 1'b1, 1'b0);
    end
    repeat (4) @(posedge clk);
    #1;
    debug_out_ready = 1'b1;
    check_trace(ctm_pkg::word_t'(ctm_pkg::EV_CALL), pcs[0], tgts[0], stamp);
    check_trace(ctm_pkg::word_t'(ctm_pkg::EV_CALL), pcs[1], tgts[1], stamp);
    expect_quiet("the two stored events");
    reg_access(1'b0, ctm_pkg::REG_DROP, '0, rtype, rdata);
    check_word("drop count", 16'd3, rdata); // Three lost.
  endtask

  task automatic test_errors();
    ctm_pkg::word_t rtype, rdata;
    cur_test = "errors";
    reg_access(1'b0, 16'd9, '0, rtype, rdata);
    check_word("unknown read type", ctm_pkg::TYPE_REG_ERROR, rtype);
    reg_access(1'b1, ctm_pkg::REG_MOD_TYPE, 16'h1234, rtype, rdata);
    check_word("read-only write type", ctm_pkg::TYPE_REG_ERROR, rtype);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and report.
  ////////////////////////////////////////////////////////////

  initial begin
    int wait_cnt;
    int total;
    errors          = 0;
    id              = DUT_ID;
    debug_in        = '0;
    debug_out_ready = 1'b1;
    trace_port      = '0;
    void'($urandom(32'hb949_3d4d));
    wait_cnt = 0;
    while (rst_n !== 1'b1 && wait_cnt < 20) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("reset was never released");
    end
    @(posedge clk);
    #1;
    cur_test = "reset";
    check_word("debug_in_ready", 16'd1, ctm_pkg::word_t'(debug_in_ready));
    check_word("debug_out valid", 16'd0, ctm_pkg::word_t'(debug_out.valid));
    test_mod_type();
    test_config();
    test_trace();
    test_no_event();
    test_backpressure();
    test_errors();
    total = errors + ctm_msp430_i.u_checker.assert_fails;
    $display("errors: %0d check, %0d assertion", errors, ctm_msp430_i.u_checker.assert_fails);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
